// File: sources.f
+incdir+include
design/ddrc_seq_pkg.sv
design/seq_sdp_ram.sv
design/seq_ctrl_regs.sv
design/cmd_sequencer.sv
design/chn_buf_ctrl.sv
design/ddrc_sequencer_top.sv
verification/tb_ddrc_seq.sv

// File: Bender.yml
package:
  name: ddrc_sequencer

sources:
  - files:
      - design/ddrc_seq_pkg.sv
      - design/seq_sdp_ram.sv
      - design/seq_ctrl_regs.sv
      - design/cmd_sequencer.sv
      - design/chn_buf_ctrl.sv
      - design/ddrc_sequencer_top.sv
  - target: test
    include_dirs:
      - include
    files:
      - verification/tb_ddrc_seq.sv

// File: include/tb_ddrc_seq_tasks.svh
/*
 * Directed tests for the DDR3 command sequencer testbench.
 * Command word builders, load/start/wait helpers and the six tests.
 */
`ifndef TB_DDRC_SEQ_TASKS_SVH
`define TB_DDRC_SEQ_TASKS_SVH

localparam logic [2:0] RCW_ACT = 3'b011;   // ras cas we, active low
localparam logic [2:0] RCW_RD  = 3'b101;
localparam logic [2:0] RCW_WR  = 3'b100;
localparam logic [2:0] RCW_PRE = 3'b010;
localparam logic [3:0] F_AP  = 4'b1000;
localparam logic [3:0] F_WR  = 4'b0100;
localparam logic [3:0] F_RD  = 4'b0010;
localparam logic [3:0] F_CKE = 4'b0001;

function automatic cmd_word_t build_cmd(input logic [2:0] rcw, input logic [14:0] a,
                                        input logic [2:0] ba, input logic [3:0] flags);
    cmd_word_t w;
    w = '0;
    {w.ras, w.cas, w.we} = rcw;
    w.addr = a;
    w.ba   = ba;
    {w.add_pause, w.buf_wr, w.buf_rd, w.cke_inv} = flags;
    return w;
endfunction

function automatic cmd_word_t nop_word(input int pause, input logic done);
    cmd_word_t w;
    w = '0;
    {w.ras, w.cas, w.we} = 3'b111;
    w.addr[9:0] = pause[9:0];   // pause length
    w.addr[10]  = done;
    return w;
endfunction

task automatic init_inputs();
    {cmd0_we, cmd1_we, run_seq, port0_re, port1_we, cfg_we} = '0;
    {cmd0_addr, cmd1_addr, cmd0_data, cmd1_data, run_addr, run_chn} = '0;
    {port0_page, port0_int_page, port0_addr, port1_page, port1_int_page} = '0;
    {port1_addr, port1_data, cfg_addr, cfg_data, sd_rdata} = '0;
endtask

task automatic fail_timeout(input string what);
    errors++;
    $display("timeout while waiting for %s", what);
    $display("checks: %0d, errors: %0d", checks, errors);
    $display("TEST FAIL");
    $finish;
endtask

task automatic check_val(input string name, input logic [63:0] exp, input logic [63:0] act);
    checks++;
    assert (exp === act) else begin
        errors++;
        $display("[ERROR] %s: expected %0h, actual %0h", name, exp, act);
    end
endtask

task automatic check_gap(input string name, input int min_gap, input int act);
    checks++;
    assert (act >= min_gap) else begin
        errors++;
        $display("[ERROR] %s: expected at least %0d, actual %0d", name, min_gap, act);
    end
endtask

task automatic load_cmd(input logic bank, input int addr, input cmd_word_t w,
                        input logic expect_it);
    @(negedge mclk);
    if (bank) begin
        cmd1_we   = 1'b1;
        cmd1_addr = CMD_ADDR_BITS'(addr);
        cmd1_data = w;
    end else begin
        cmd0_we   = 1'b1;
        cmd0_addr = CMD_ADDR_BITS'(addr);
        cmd0_data = w;
    end
    @(negedge mclk);
    cmd0_we = 1'b0;
    cmd1_we = 1'b0;
    if (expect_it) exp_q.push_back(w);
endtask

task automatic cfg_write(input logic [1:0] addr, input logic [7:0] data);
    @(negedge mclk);
    cfg_we   = 1'b1;
    cfg_addr = addr;
    cfg_data = data;
    @(negedge mclk);
    cfg_we = 1'b0;
endtask

task automatic start_seq(input logic [10:0] addr, input chn_sel_t chn);
    log_cyc.delete();
    log_a.delete();
    log_ba.delete();
    log_rcw.delete();
    log_odt.delete();
    log_cke.delete();
    wdata_q.delete();
    done_cnt = 0;
    @(negedge mclk);
    run_seq  = 1'b1;
    run_addr = addr;
    run_chn  = chn;
    @(negedge mclk);
    run_seq = 1'b0;
endtask

task automatic wait_done(input string name);
    int i;
    i = 0;
    while (!run_done && i < 3000) begin   // pulse is one cycle wide
        @(negedge mclk);
        i++;
    end
    if (!run_done) fail_timeout({name, " run_done"});
    @(negedge mclk);
    check_val({name, " busy after done"}, 0, run_busy);
    check_val({name, " done pulses"}, 1, done_cnt);
endtask

task automatic check_log(input string name);
    check_val({name, " command count"}, exp_q.size(), log_a.size());
    for (int i = 0; i < exp_q.size() && i < log_a.size(); i++) begin
        check_val({name, " addr"}, exp_q[i].addr, log_a[i]);
        check_val({name, " bank"}, exp_q[i].ba, log_ba[i]);
        check_val({name, " ras/cas/we"}, {exp_q[i].ras, exp_q[i].cas, exp_q[i].we},
                  log_rcw[i]);
        check_val({name, " odt"}, exp_q[i].odt, log_odt[i]);
    end
endtask

task automatic test_cmd_order();
    cmd_word_t wr_odt;
    exp_q.delete();
    wr_odt     = build_cmd(RCW_WR, 15'h0040, 3'd2, 4'h0);
    wr_odt.odt = 1'b1;   // odt raised with the write
    load_cmd(0, 0, build_cmd(RCW_ACT, 15'h0123, 3'd1, 4'h0), 1);
    load_cmd(0, 1, wr_odt, 1);
    load_cmd(0, 2, build_cmd(RCW_PRE, 15'h0400, 3'd3, 4'h0), 1);
    load_cmd(0, 3, nop_word(0, 1), 0);
    start_seq(11'h000, 4'd0);
    wait_done("cmd_order");
    check_log("cmd_order");
endtask

task automatic test_bank1_offset();
    exp_q.delete();
    load_cmd(1, 'h0f, build_cmd(RCW_ACT, 15'h7fff, 3'd7, 4'h0), 0);   // before offset
    load_cmd(1, 'h10, build_cmd(RCW_ACT, 15'h2abc, 3'd5, 4'h0), 1);
    load_cmd(1, 'h11, build_cmd(RCW_RD, 15'h0008, 3'd5, 4'h0), 1);
    load_cmd(1, 'h12, nop_word(0, 1), 0);
    start_seq({1'b1, 10'h010}, 4'd0);
    wait_done("bank1_offset");
    check_log("bank1_offset");
endtask

task automatic test_pause();
    exp_q.delete();
    load_cmd(0, 'h20, build_cmd(RCW_ACT, 15'h0001, 3'd0, 4'h0), 1);
    load_cmd(0, 'h21, nop_word(5, 0), 0);
    load_cmd(0, 'h22, build_cmd(RCW_ACT, 15'h0002, 3'd1, 4'h0), 1);
    load_cmd(0, 'h23, build_cmd(RCW_PRE, 15'h0400, 3'd1, F_AP), 1);
    load_cmd(0, 'h24, build_cmd(RCW_ACT, 15'h0003, 3'd2, 4'h0), 1);
    load_cmd(0, 'h25, nop_word(0, 1), 0);
    start_seq(11'h020, 4'd0);
    wait_done("pause");
    check_log("pause");
    if (log_cyc.size() >= 4) begin
        check_gap("pause nop gap", 6, log_cyc[1] - log_cyc[0]);
        check_gap("add_pause gap", 2, log_cyc[3] - log_cyc[2]);
    end
endtask

task automatic test_write_data();
    buf_word_t words[4];
    for (int i = 0; i < 4; i++) begin
        words[i] = {$random(seed), $random(seed)};
        @(negedge mclk);
        port1_we   = 1'b1;
        port1_page = 2'd2;
        port1_addr = BUF_WORD_BITS'(i);
        port1_data = words[i];
    end
    @(negedge mclk);
    port1_we = 1'b0;
    port1_int_page = 2'd2;
    for (int i = 0; i < 3; i++) begin
        load_cmd(0, 'h40 + i, build_cmd(RCW_WR, ADDRESS_NUMBER'(16 * i), 3'd0, F_RD), 0);
    end
    load_cmd(0, 'h43, nop_word(0, 1), 0);
    start_seq(11'h040, 4'd1);
    wait_done("write_data");
    check_val("write_data word count", 3, wdata_q.size());
    for (int i = 0; i < 3 && i < wdata_q.size(); i++) begin
        check_val("write_data word", words[i], wdata_q[i]);
    end
endtask

task automatic test_read_capture();
    cfg_write(2'd0, 8'd3);
    port0_int_page = 2'd1;
    load_cmd(0, 'h60, build_cmd(RCW_RD, 15'h0000, 3'd0, F_WR), 0);
    load_cmd(0, 'h61, nop_word(2, 0), 0);
    load_cmd(0, 'h62, build_cmd(RCW_RD, 15'h0008, 3'd0, F_WR), 0);
    load_cmd(0, 'h63, build_cmd(RCW_RD, 15'h0010, 3'd0, F_WR), 0);
    load_cmd(0, 'h64, nop_word(0, 1), 0);
    start_seq(11'h060, 4'd0);
    wait_done("read_capture");
    repeat (8) @(negedge mclk);   // last capture lands delay+2 after its command
    check_val("read_capture command count", 3, log_cyc.size());
    for (int i = 0; i < 3 && i < log_cyc.size(); i++) begin
        @(negedge mclk);
        port0_re   = 1'b1;
        port0_page = 2'd1;
        port0_addr = BUF_WORD_BITS'(i);
        @(negedge mclk);
        port0_re = 1'b0;
        check_val("read_capture word", log_cyc[i] + 4, port0_data);
    end
endtask

task automatic test_config();
    int i;
    exp_q.delete();
    cfg_write(2'd1, 8'd1);
    load_cmd(0, 'h80, build_cmd(RCW_ACT, 15'h0005, 3'd0, 4'h0), 1);
    load_cmd(0, 'h81, build_cmd(RCW_PRE, 15'h0000, 3'd0, F_CKE), 1);
    load_cmd(0, 'h82, nop_word(0, 1), 0);
    start_seq(11'h080, 4'd0);
    wait_done("config_cke");
    check_log("config_cke");
    if (log_cke.size() >= 2) begin
        check_val("config_cke plain", 1, log_cke[0]);
        check_val("config_cke inverted", 0, log_cke[1]);
    end
    load_cmd(0, 'ha0, build_cmd(RCW_ACT, 15'h0006, 3'd0, 4'h0), 0);
    load_cmd(0, 'ha1, nop_word(1000, 0), 0);
    load_cmd(0, 'ha2, build_cmd(RCW_ACT, 15'h0007, 3'd0, 4'h0), 0);
    load_cmd(0, 'ha3, nop_word(0, 1), 0);
    start_seq(11'h0a0, 4'd0);
    i = 0;
    while (log_a.size() == 0 && i < 50) begin
        @(negedge mclk);
        i++;
    end
    if (log_a.size() == 0) fail_timeout("first command before abort");
    repeat (5) @(negedge mclk);   // well inside the long pause
    cfg_write(2'd2, 8'd1);
    i = 0;
    while (run_busy && i < 20) begin
        @(negedge mclk);
        i++;
    end
    if (run_busy) fail_timeout("run_busy to drop on abort");
    repeat (3) @(negedge mclk);
    check_val("abort done pulses", 0, done_cnt);
    check_val("abort sd_rst_n", 0, sd_rst_n);
    check_val("abort command count", 1, log_a.size());
    cfg_write(2'd2, 8'd0);
    check_val("release sd_rst_n", 1, sd_rst_n);
endtask

`endif

// File: verification/tb_ddrc_seq.sv
/*
 * Testbench for the DDR3 command sequencer.
 * Clock, reset, DUT, a pin monitor that logs commands and write data,
 * sd_rdata driven as the cycle count, directed tests and final report.
 */
`timescale 1ns/1ps

module tb_ddrc_seq
    import ddrc_seq_pkg::*;
();

    logic                      mclk = 1'b0;
    logic                      rst;
    logic                      cmd0_we, cmd1_we;
    logic [CMD_ADDR_BITS-1:0]  cmd0_addr, cmd1_addr;
    cmd_word_t                 cmd0_data, cmd1_data;
    logic                      run_seq;
    logic [CMD_ADDR_BITS:0]    run_addr;      // msb is bank
    chn_sel_t                  run_chn;
    logic                      run_busy, run_done;
    logic [ADDRESS_NUMBER-1:0] sd_a;
    logic [2:0]                sd_ba;
    logic                      sd_ras, sd_cas, sd_we, sd_odt, sd_cke, sd_rst_n;
    buf_word_t                 sd_wdata, sd_rdata, port0_data, port1_data;
    logic                      sd_wdata_valid;
    logic                      port0_re, port1_we;
    logic [BUF_PAGE_BITS-1:0]  port0_page, port0_int_page, port1_page, port1_int_page;
    logic [BUF_WORD_BITS-1:0]  port0_addr, port1_addr;
    logic                      cfg_we;
    logic [1:0]                cfg_addr;
    logic [7:0]                cfg_data;

    int        cyc = 0;          // posedge count
    int        errors = 0;
    int        checks = 0;
    int        done_cnt = 0;     // run_done pulses since last start
    integer    seed;
    int        log_cyc[$];       // command log, one entry per non-NOP
    logic [14:0] log_a[$];
    logic [2:0]  log_ba[$];
    logic [2:0]  log_rcw[$];
    logic        log_odt[$];
    logic        log_cke[$];
    buf_word_t   wdata_q[$];     // sd_wdata seen with valid
    cmd_word_t   exp_q[$];       // commands expected on the pins

    always #5 mclk = ~mclk;

    always @(posedge mclk) cyc <= cyc + 1;

    ddrc_sequencer_top u_dut (.*);

    // pins change on posedge, sampled here mid-cycle
    always @(negedge mclk) begin
        sd_rdata = buf_word_t'(cyc);   // captured value tells the sample cycle
        if (!(sd_ras && sd_cas && sd_we)) begin
            log_cyc.push_back(cyc);
            log_a.push_back(sd_a);
            log_ba.push_back(sd_ba);
            log_rcw.push_back({sd_ras, sd_cas, sd_we});
            log_odt.push_back(sd_odt);
            log_cke.push_back(sd_cke);
            $display("cycle %0d: cmd rcw=%b a=%h ba=%0d", cyc, {sd_ras, sd_cas, sd_we},
                     sd_a, sd_ba);
        end
        if (sd_wdata_valid) begin
            wdata_q.push_back(sd_wdata);
            $display("cycle %0d: wdata %h", cyc, sd_wdata);
            assert (!(sd_ras && sd_cas && sd_we)) else begin
                errors++;
                $display("write data valid without a command at cycle %0d", cyc);
            end
        end
        if (run_done) done_cnt++;
    end

    `include "tb_ddrc_seq_tasks.svh"

    initial begin
        seed = 22;
        rst  = 1'b1;
        init_inputs();
        repeat (2) @(posedge mclk);
        @(negedge mclk);
        rst = 1'b0;
        test_cmd_order();
        test_bank1_offset();
        test_pause();
        test_write_data();
        test_read_capture();
        test_config();
        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

// File: design/ddrc_sequencer_top.sv
/*
 * DDR3 command sequencer top level.
 * Two command banks, the sequencer core, channel buffers
 * and configuration registers, all on mclk.
 */
`timescale 1ns/1ps

module ddrc_sequencer_top
    import ddrc_seq_pkg::*;
#(
    parameter int unsigned CMD_DEPTH = 1024
) (
    input  logic                      mclk,
    input  logic                      rst,
    input  logic                      cmd0_we,        // manual bank load
    input  logic [CMD_ADDR_BITS-1:0]  cmd0_addr,
    input  cmd_word_t                 cmd0_data,
    input  logic                      cmd1_we,        // auto bank load
    input  logic [CMD_ADDR_BITS-1:0]  cmd1_addr,
    input  cmd_word_t                 cmd1_data,
    input  logic                      run_seq,
    input  logic [CMD_ADDR_BITS:0]    run_addr,
    input  chn_sel_t                  run_chn,
    output logic                      run_busy,
    output logic                      run_done,
    output logic [ADDRESS_NUMBER-1:0] sd_a,
    output logic [2:0]                sd_ba,
    output logic                      sd_ras,
    output logic                      sd_cas,
    output logic                      sd_we,
    output logic                      sd_odt,
    output logic                      sd_cke,
    output logic                      sd_rst_n,
    output buf_word_t                 sd_wdata,
    output logic                      sd_wdata_valid,
    input  buf_word_t                 sd_rdata,
    input  logic                      port0_re,
    input  logic [BUF_PAGE_BITS-1:0]  port0_page,
    input  logic [BUF_PAGE_BITS-1:0]  port0_int_page,
    input  logic [BUF_WORD_BITS-1:0]  port0_addr,
    output buf_word_t                 port0_data,
    input  logic                      port1_we,
    input  logic [BUF_PAGE_BITS-1:0]  port1_page,
    input  logic [BUF_PAGE_BITS-1:0]  port1_int_page,
    input  logic [BUF_WORD_BITS-1:0]  port1_addr,
    input  buf_word_t                 port1_data,
    input  logic                      cfg_we,
    input  logic [1:0]                cfg_addr,
    input  logic [7:0]                cfg_data
);

    cmd_word_t                cmd0_word, cmd1_word;
    logic [CMD_ADDR_BITS-1:0] cmd_raddr;
    logic                     cmd0_re, cmd1_re;
    logic                     buf_rd, buf_wr;
    logic [3:0]               wbuf_delay;
    logic                     cke_en, ddr_rst;

    assign sd_rst_n = ~ddr_rst;   // pin is active low

    seq_sdp_ram #(.payload_t(cmd_word_t), .DEPTH(CMD_DEPTH)) u_cmd0_ram (
        .mclk(mclk), .we(cmd0_we), .waddr(cmd0_addr), .wdata(cmd0_data),
        .re(cmd0_re), .raddr(cmd_raddr), .rdata(cmd0_word)
    );

    seq_sdp_ram #(.payload_t(cmd_word_t), .DEPTH(CMD_DEPTH)) u_cmd1_ram (
        .mclk(mclk), .we(cmd1_we), .waddr(cmd1_addr), .wdata(cmd1_data),
        .re(cmd1_re), .raddr(cmd_raddr), .rdata(cmd1_word)
    );

    cmd_sequencer u_seq (
        .mclk(mclk), .rst(rst), .run_seq(run_seq), .run_addr(run_addr),
        .ddr_rst(ddr_rst), .cke_en(cke_en), .cmd0_word(cmd0_word), .cmd1_word(cmd1_word),
        .cmd_raddr(cmd_raddr), .cmd0_re(cmd0_re), .cmd1_re(cmd1_re),
        .run_busy(run_busy), .run_done(run_done),
        .sd_a(sd_a), .sd_ba(sd_ba), .sd_ras(sd_ras), .sd_cas(sd_cas), .sd_we(sd_we),
        .sd_odt(sd_odt), .sd_cke(sd_cke), .buf_rd(buf_rd), .buf_wr(buf_wr)
    );

    chn_buf_ctrl u_buf (
        .mclk(mclk), .rst(rst), .run_seq(run_seq), .run_chn(run_chn),
        .port0_int_page(port0_int_page), .port1_int_page(port1_int_page),
        .buf_rd(buf_rd), .buf_wr(buf_wr), .wbuf_delay(wbuf_delay), .sd_rdata(sd_rdata),
        .port1_we(port1_we), .port1_page(port1_page), .port1_addr(port1_addr),
        .port1_data(port1_data), .port0_re(port0_re), .port0_page(port0_page),
        .port0_addr(port0_addr), .port0_data(port0_data),
        .sd_wdata(sd_wdata), .sd_wdata_valid(sd_wdata_valid)
    );

    seq_ctrl_regs u_regs (
        .mclk(mclk), .rst(rst), .cfg_we(cfg_we), .cfg_addr(cfg_addr), .cfg_data(cfg_data),
        .wbuf_delay(wbuf_delay), .cke_en(cke_en), .ddr_rst(ddr_rst)
    );

endmodule

// File: design/chn_buf_ctrl.sv
/*
 * Channel buffer control.
 * Latches channel and page at start, steps the buffer address, delays
 * the capture strobe and holds the write (ch 1) and read (ch 0) buffers.
 */
`timescale 1ns/1ps

module chn_buf_ctrl
    import ddrc_seq_pkg::*;
(
    input  logic                     mclk,
    input  logic                     rst,
    input  logic                     run_seq,
    input  chn_sel_t                 run_chn,
    input  logic [BUF_PAGE_BITS-1:0] port0_int_page,
    input  logic [BUF_PAGE_BITS-1:0] port1_int_page,
    input  logic                     buf_rd,
    input  logic                     buf_wr,
    input  logic [3:0]               wbuf_delay,
    input  buf_word_t                sd_rdata,
    input  logic                     port1_we,
    input  logic [BUF_PAGE_BITS-1:0] port1_page,
    input  logic [BUF_WORD_BITS-1:0] port1_addr,
    input  buf_word_t                port1_data,
    input  logic                     port0_re,
    input  logic [BUF_PAGE_BITS-1:0] port0_page,
    input  logic [BUF_WORD_BITS-1:0] port0_addr,
    output buf_word_t                port0_data,
    output buf_word_t                sd_wdata,
    output logic                     sd_wdata_valid
);

    localparam int unsigned BUF_DEPTH = 1 << (BUF_PAGE_BITS + BUF_WORD_BITS);

    chn_sel_t                 chn_q;
    logic [BUF_PAGE_BITS-1:0] buf_page;
    logic [1:0]               chn_1hot;   // only channels 0 and 1
    logic                     run_seq_d;
    buf_addr_t                buf_addr;   // shared by read and capture
    logic [15:0]              wr_line;    // capture strobe delay line
    logic                     cap_we;     // sd_rdata sampled this cycle

    always_ff @(posedge mclk or posedge rst) begin
        if (rst) begin
            chn_q          <= '0;
            buf_page       <= '0;
            chn_1hot       <= '0;
            run_seq_d      <= 1'b0;
            buf_addr       <= '0;
            wr_line        <= '0;
            cap_we         <= 1'b0;
            sd_wdata_valid <= 1'b0;
        end else begin
            run_seq_d <= run_seq;
            if (run_seq) begin
                chn_q    <= run_chn;
                buf_page <= (run_chn == chn_sel_t'(0)) ? port0_int_page : port1_int_page;
            end
            chn_1hot <= {chn_q == chn_sel_t'(1), chn_q == chn_sel_t'(0)};
            if (run_seq_d)             buf_addr <= {buf_page, {BUF_WORD_BITS{1'b0}}};
            else if (buf_rd || cap_we) buf_addr <= buf_addr + 1'b1;   // wraps within buffer
            wr_line        <= {wr_line[14:0], buf_wr};   // [0] aligned with pins
            cap_we         <= wr_line[wbuf_delay];       // delay+1 after the command
            sd_wdata_valid <= buf_rd & chn_1hot[1];
        end
    end

    // channel 1, filled by port 1, drained onto sd_wdata
    seq_sdp_ram #(
        .payload_t (buf_word_t),
        .DEPTH     (BUF_DEPTH)
    ) u_buf1_ram (
        .mclk  (mclk),
        .we    (port1_we),
        .waddr ({port1_page, port1_addr}),
        .wdata (port1_data),
        .re    (buf_rd & chn_1hot[1]),
        .raddr (buf_addr),
        .rdata (sd_wdata)
    );

    // channel 0, filled from sd_rdata, read out by port 0
    seq_sdp_ram #(
        .payload_t (buf_word_t),
        .DEPTH     (BUF_DEPTH)
    ) u_buf0_ram (
        .mclk  (mclk),
        .we    (cap_we & chn_1hot[0]),
        .waddr (buf_addr),
        .wdata (sd_rdata),
        .re    (port0_re),
        .raddr ({port0_page, port0_addr}),
        .rdata (port0_data)
    );

    a_rd_wr_excl: assert property (@(posedge mclk) disable iff (rst)
        !(buf_rd && buf_wr));

endmodule

// File: design/cmd_sequencer.sv
/*
 * DDR3 command sequencer core.
 * Fetches command words from one of two banks, decodes NOP pause and
 * done, registers the DDR command pins and issues buffer strobes.
 */
`timescale 1ns/1ps

module cmd_sequencer
    import ddrc_seq_pkg::*;
(
    input  logic                      mclk,
    input  logic                      rst,
    input  logic                      run_seq,
    input  logic [CMD_ADDR_BITS:0]    run_addr,   // msb selects bank
    input  logic                      ddr_rst,
    input  logic                      cke_en,
    input  cmd_word_t                 cmd0_word,
    input  cmd_word_t                 cmd1_word,
    output logic [CMD_ADDR_BITS-1:0]  cmd_raddr,
    output logic                      cmd0_re,
    output logic                      cmd1_re,
    output logic                      run_busy,
    output logic                      run_done,
    output logic [ADDRESS_NUMBER-1:0] sd_a,
    output logic [2:0]                sd_ba,
    output logic                      sd_ras,
    output logic                      sd_cas,
    output logic                      sd_we,
    output logic                      sd_odt,
    output logic                      sd_cke,
    output logic                      buf_rd,
    output logic                      buf_wr
);

    logic [2:0]                cmd_busy;   // [0] fetch, [1] counter, [2] done check
    logic                      cmd_sel;    // 0 manual bank, 1 auto bank
    logic [CMD_ADDR_BITS-1:0]  cmd_addr;
    logic                      cmd_fetch;  // ram output valid this cycle
    logic [CMD_PAUSE_BITS-1:0] pause_cntr;
    logic                      done_pend;  // done NOP seen, waiting out its pause
    logic                      cke_inv_q;  // last cke_inv, held between commands
    cmd_word_t                 cmd_word;
    logic                      cmd_nop;
    logic                      cmd_done;
    logic [CMD_PAUSE_BITS-1:0] pause_len;
    logic                      pause;
    logic                      fetch_en;
    logic                      seq_end;

    assign cmd_word  = cmd_sel ? cmd1_word : cmd0_word;
    assign cmd_nop   = cmd_word.ras & cmd_word.cas & cmd_word.we;
    assign pause_len = cmd_word.addr[CMD_PAUSE_BITS-1:0];
    assign cmd_done  = cmd_nop & cmd_word.addr[CMD_DONE_BIT];

    // stop on the word itself, then hold until counter is nearly out
    assign pause = cmd_fetch ?
        (cmd_word.add_pause | cmd_done | (cmd_nop & (pause_len != '0))) :
        (done_pend | (pause_cntr[CMD_PAUSE_BITS-1:1] != '0));

    assign fetch_en  = cmd_busy[0] & ~pause & ~ddr_rst;
    assign cmd0_re   = fetch_en & ~cmd_sel;
    assign cmd1_re   = fetch_en & cmd_sel;
    assign cmd_raddr = cmd_addr;
    assign seq_end   = cmd_busy[2] & done_pend & (pause_cntr[CMD_PAUSE_BITS-1:1] == '0);
    assign run_busy  = cmd_busy[0];     // earliest stage
    assign buf_rd    = cmd_fetch & cmd_word.buf_rd; // ram read ahead of the pins
    assign buf_wr    = cmd_fetch & cmd_word.buf_wr;

    always_ff @(posedge mclk or posedge rst) begin
        if (rst) begin
            cmd_busy   <= '0;
            cmd_sel    <= 1'b0;
            cmd_addr   <= '0;
            cmd_fetch  <= 1'b0;
            pause_cntr <= '0;
            done_pend  <= 1'b0;
            run_done   <= 1'b0;
        end else begin
            if (ddr_rst || seq_end) cmd_busy <= '0;   // abort or finish
            else                    cmd_busy <= {cmd_busy[1:0], run_seq | cmd_busy[0]};
            if (run_seq) begin
                cmd_sel  <= run_addr[CMD_ADDR_BITS];
                cmd_addr <= run_addr[CMD_ADDR_BITS-1:0];
            end else if (fetch_en) begin
                cmd_addr <= cmd_addr + 1'b1;
            end
            cmd_fetch <= fetch_en;
            if (!cmd_busy[1])             pause_cntr <= '0;
            else if (cmd_fetch && cmd_nop) pause_cntr <= pause_len;   // zero for plain NOP
            else if (pause_cntr != '0)    pause_cntr <= pause_cntr - 1'b1;
            if (ddr_rst || seq_end)          done_pend <= 1'b0;
            else if (cmd_fetch && cmd_done) done_pend <= 1'b1;
            run_done <= seq_end & ~ddr_rst;   // no done pulse on abort
        end
    end

    // command pins, NOP whenever no word is valid
    always_ff @(posedge mclk or posedge rst) begin
        if (rst) begin
            sd_a      <= '0;
            sd_ba     <= '0;
            sd_ras    <= 1'b1;
            sd_cas    <= 1'b1;
            sd_we     <= 1'b1;
            sd_odt    <= 1'b0;
            sd_cke    <= 1'b0;
            cke_inv_q <= 1'b0;
        end else begin
            sd_ras <= cmd_fetch ? cmd_word.ras : 1'b1;
            sd_cas <= cmd_fetch ? cmd_word.cas : 1'b1;
            sd_we  <= cmd_fetch ? cmd_word.we  : 1'b1;
            if (cmd_fetch) begin
                sd_a      <= cmd_word.addr;
                sd_ba     <= cmd_word.ba;
                sd_odt    <= cmd_word.odt;      // level, held until next word
                cke_inv_q <= cmd_word.cke_inv;
            end
            sd_cke <= cke_en ^ (cmd_fetch ? cmd_word.cke_inv : cke_inv_q);
        end
    end

    a_start_idle: assert property (@(posedge mclk) disable iff (rst)
        run_seq |-> !run_busy);
    a_done_end: assert property (@(posedge mclk) disable iff (rst)
        run_done |-> $past(run_busy) && !run_busy);

endmodule

// File: design/seq_ctrl_regs.sv
/*
 * Sequencer configuration registers.
 * Read capture delay, DDR clock enable level and soft DDR reset,
 * written one at a time over a small address/data port.
 */
`timescale 1ns/1ps

module seq_ctrl_regs (
    input  logic       mclk,
    input  logic       rst,
    input  logic       cfg_we,
    input  logic [1:0] cfg_addr,
    input  logic [7:0] cfg_data,
    output logic [3:0] wbuf_delay,
    output logic       cke_en,
    output logic       ddr_rst
);

    localparam logic [1:0] REG_WBUF_DLY = 2'd0; // capture delay, 0..15
    localparam logic [1:0] REG_CKE_EN   = 2'd1; // cke level before xor
    localparam logic [1:0] REG_DDR_RST  = 2'd2; // soft reset, aborts sequence

    always_ff @(posedge mclk or posedge rst) begin
        if (rst) begin
            wbuf_delay <= '0;
            cke_en     <= 1'b0;   // cke low out of reset
            ddr_rst    <= 1'b0;
        end else if (cfg_we) begin
            case (cfg_addr)
                REG_WBUF_DLY: wbuf_delay <= cfg_data[3:0];
                REG_CKE_EN:   cke_en     <= cfg_data[0];
                REG_DDR_RST:  ddr_rst    <= cfg_data[0];
                default: begin
                    // address 3 unused, writes ignored
                end
            endcase
        end
    end

endmodule

// File: design/seq_sdp_ram.sv
/*
 * Simple dual-port RAM, one clock.
 * Write port and a read port with registered output,
 * payload type set per instance (command words or buffer words).
 */
`timescale 1ns/1ps

module seq_sdp_ram #(
    parameter type         payload_t = logic [31:0],
    parameter int unsigned DEPTH     = 1024
) (
    input  logic                     mclk,
    input  logic                     we,
    input  logic [$clog2(DEPTH)-1:0] waddr,
    input  payload_t                 wdata,
    input  logic                     re,
    input  logic [$clog2(DEPTH)-1:0] raddr,
    output payload_t                 rdata
);

    payload_t mem [DEPTH];     // contents loaded over the write port

    always_ff @(posedge mclk) begin
        if (we) begin
            mem[waddr] <= wdata;
        end
    end

    // output held while re is low, sequencer relies on that during pauses
    always_ff @(posedge mclk) begin
        if (re) begin
            rdata <= mem[raddr];
        end
    end

endmodule

// File: design/ddrc_seq_pkg.sv
/*
 * DDR3 command sequencer shared definitions.
 * Command word layout, pause and done encoding inside NOP words,
 * and the channel buffer word, address and channel types.
 */
package ddrc_seq_pkg;

    localparam int unsigned ADDRESS_NUMBER = 15;    // ddr3 address pins, 4Gb part
    localparam int unsigned CMD_ADDR_BITS  = 10;    // 1k words per command bank
    localparam int unsigned CMD_PAUSE_BITS = 10;    // pause length in a NOP word
    localparam int unsigned CMD_DONE_BIT   = 10;    // done flag position in sd_a field
    localparam int unsigned BUF_PAGE_BITS  = 2;     // 4 pages per channel buffer
    localparam int unsigned BUF_WORD_BITS  = 7;     // 128 words per page

    // one sequencer step, 32 bits total
    typedef struct packed {
        logic [5:0]                spare;     // reserved, keep zero
        logic                      add_pause; // force one NOP after this command
        logic                      buf_wr;    // capture sd_rdata into channel buffer
        logic                      buf_rd;    // send next buffer word on sd_wdata
        logic                      cke_inv;   // xor-ed with cke_en
        logic                      odt;
        logic                      we;        // active low
        logic                      cas;       // active low
        logic                      ras;       // active low
        logic [2:0]                ba;
        logic [ADDRESS_NUMBER-1:0] addr;      // pause/done bits when NOP
    } cmd_word_t;

    typedef logic [63:0] buf_word_t;                           // channel buffer data
    typedef logic [BUF_PAGE_BITS+BUF_WORD_BITS-1:0] buf_addr_t; // {page, word index}
    typedef logic [3:0] chn_sel_t;                             // channel number

endpackage
